/* verilog/mmu_pkg.sv */
// address translation types
`default_nettype none

package mmu_pkg;

    // memory exception raised in the execute stage
    typedef enum logic [1:0] {
        exc_none = 2'd0,
        exc_ale  = 2'd1,   // misaligned access
        exc_adem = 2'd2,   // privileged address from user level
        exc_tlbr = 2'd3    // mapped access with no translation
    } exc_code_e;

    // one direct-mapped window
    typedef struct packed {
        logic       plv0;   // usable at plv 0
        logic       plv3;   // usable at plv 3
        logic [2:0] vseg;   // va[31:29] to match
        logic [2:0] pseg;   // pa[31:29] on a hit
    } dmw_t;

    // translation state seen by the memory unit
    typedef struct packed {
        logic            da;    // direct address mode
        logic            pg;    // paging mode
        logic [1:0]      plv;   // current privilege level
        dmw_t [1:0]      dmw;
    } xlat_cfg_t;

endpackage

`default_nettype wire

/* verilog/exe_pkg.sv */
// execute stage types
`default_nettype none

package exe_pkg;

    typedef enum logic [4:0] {
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_slt   = 5'd2,
        op_sltu  = 5'd3,
        op_and   = 5'd4,
        op_or    = 5'd5,
        op_xor   = 5'd6,
        op_nor   = 5'd7,
        op_sll   = 5'd8,
        op_srl   = 5'd9,
        op_sra   = 5'd10,
        op_lui   = 5'd11,
        op_div   = 5'd12,
        op_mod   = 5'd13,
        op_divu  = 5'd14,
        op_modu  = 5'd15,
        op_load  = 5'd16,
        op_store = 5'd17
    } exe_op_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // from decode
    typedef struct packed {
        exe_op_e     op;
        logic [31:0] src1;
        logic [31:0] src2;          // offset for load and store
        logic [31:0] store_data;
        mem_size_e   size;
        logic        load_unsigned;
        logic [4:0]  dest;
        logic        gr_we;
        logic [31:0] pc;
    } exe_req_t;

    // to the memory stage
    typedef struct packed {
        logic              [31:0] result;   // virtual address for memory ops
        logic              [4:0]  dest;
        logic                     gr_we;
        logic                     is_load;
        logic                     load_unsigned;
        mem_size_e                size;
        logic              [31:0] pc;
        logic                     exc_valid;
        mmu_pkg::exc_code_e       exc_code;
    } exe_resp_t;

    // data memory request
    typedef struct packed {
        logic        wr;
        mem_size_e   size;
        logic [31:0] addr;   // physical
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* verilog/exe_alu.sv */
// integer alu
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
    input  exe_pkg::exe_op_e op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      alu_result
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shamt;
    logic        lt_signed;
    logic        lt_unsigned;

    assign sum         = src1 + src2;   // also the effective address
    assign diff        = src1 - src2;
    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            exe_pkg::op_add:   alu_result = sum;
            exe_pkg::op_sub:   alu_result = diff;
            exe_pkg::op_slt:   alu_result = {31'd0, lt_signed};
            exe_pkg::op_sltu:  alu_result = {31'd0, lt_unsigned};
            exe_pkg::op_and:   alu_result = src1 & src2;
            exe_pkg::op_or:    alu_result = src1 | src2;
            exe_pkg::op_xor:   alu_result = src1 ^ src2;
            exe_pkg::op_nor:   alu_result = ~(src1 | src2);
            exe_pkg::op_sll:   alu_result = src1 << shamt;
            exe_pkg::op_srl:   alu_result = src1 >> shamt;
            exe_pkg::op_sra:   alu_result = $unsigned($signed(src1) >>> shamt);
            exe_pkg::op_lui:   alu_result = src2;   // immediate already placed by decode
            exe_pkg::op_load:  alu_result = sum;
            exe_pkg::op_store: alu_result = sum;
            default:           alu_result = sum;    // divide ops take the divider output
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exe_divider.sv */
// iterative restoring divider
`timescale 1ns/1ps
`default_nettype none

module exe_divider (
    input  logic             clk,
    input  logic             resetn,
    input  logic             div_start,
    input  logic             div_abort,
    input  exe_pkg::exe_op_e op,
    input  logic [31:0]      src1,   // dividend
    input  logic [31:0]      src2,   // divisor
    output logic             div_done,
    output logic [31:0]      div_result
);

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_fix
    } div_state_e;

    div_state_e  state;
    logic [4:0]  cnt;        // steps left
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dvs_q;
    logic        neg_quo;
    logic        neg_rem;
    logic        want_rem;

    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    logic [31:0] abs_a;
    logic [31:0] abs_b;
    logic [63:0] first_step;
    logic [63:0] next_step;

    // one shift-subtract step, returns {remainder, quotient}
    function automatic logic [63:0] div_step(input logic [31:0] rem,
                                             input logic [31:0] quo,
                                             input logic [31:0] dvs);
        logic [32:0] shifted;
        logic [32:0] trial;
        shifted = {rem, quo[31]};
        trial   = shifted - {1'b0, dvs};
        if (!trial[32])
            return {trial[31:0], quo[30:0], 1'b1};
        else
            return {shifted[31:0], quo[30:0], 1'b0};
    endfunction

    assign is_signed  = (op == exe_pkg::op_div) || (op == exe_pkg::op_mod);
    assign a_neg      = is_signed & src1[31];
    assign b_neg      = is_signed & src2[31];
    assign abs_a      = a_neg ? -src1 : src1;
    assign abs_b      = b_neg ? -src2 : src2;
    assign first_step = div_step(32'd0, abs_a, abs_b);   // step 1 happens at start
    assign next_step  = div_step(rem_q, quo_q, dvs_q);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= div_idle;
            div_done <= 1'b0;
        end else if (div_abort) begin
            state    <= div_idle;
            div_done <= 1'b0;
        end else if (div_start) begin
            state    <= div_run;
            div_done <= 1'b0;
        end else if (state == div_run && cnt == 5'd1) begin
            state <= div_fix;
        end else if (state == div_fix) begin
            state    <= div_idle;
            div_done <= 1'b1;   // held until abort or next start
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            {rem_q, quo_q} <= first_step;
            dvs_q    <= abs_b;
            cnt      <= 5'd31;
            neg_quo  <= (a_neg ^ b_neg) & (src2 != 32'd0);   // zero divisor keeps all ones
            neg_rem  <= a_neg;
            want_rem <= (op == exe_pkg::op_mod) || (op == exe_pkg::op_modu);
        end else if (state == div_run) begin
            {rem_q, quo_q} <= next_step;
            cnt <= cnt - 5'd1;
        end
    end

    // sign correction cycle
    always_ff @(posedge clk) begin
        if (state == div_fix) begin
            if (want_rem)
                div_result <= neg_rem ? -rem_q : rem_q;
            else
                div_result <= neg_quo ? -quo_q : quo_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/exe_lsu.sv */
// memory unit, translation and request
`timescale 1ns/1ps
`default_nettype none

module exe_lsu (
    input  logic                  slot_valid,
    input  exe_pkg::exe_req_t     slot_req,
    input  logic [31:0]           addr,   // virtual
    input  mmu_pkg::xlat_cfg_t    cfg,
    input  logic                  out_ready,
    input  logic                  flush,
    input  logic                  mem_ready,
    output mmu_pkg::exc_code_e    exc_code,
    output logic                  mem_valid,
    output exe_pkg::mem_req_t     mem_req,
    output logic                  mem_done
);

    logic        is_mem;
    logic        is_store;
    logic        plv0;
    logic        plv3;
    logic [1:0]  win_hit;
    logic [31:0] paddr;
    logic        adem;
    logic        ale;
    logic        tlbr;

    assign is_store = (slot_req.op == exe_pkg::op_store);
    assign is_mem   = is_store || (slot_req.op == exe_pkg::op_load);
    assign plv0     = (cfg.plv == 2'd0);
    assign plv3     = (cfg.plv == 2'd3);

    // both windows share one match rule
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            win_hit[i] = (addr[31:29] == cfg.dmw[i].vseg) &&
                         ((plv0 && cfg.dmw[i].plv0) || (plv3 && cfg.dmw[i].plv3));
        end
    end

    always_comb begin
        if (cfg.da)
            paddr = addr;
        else if (win_hit[0])
            paddr = {cfg.dmw[0].pseg, addr[28:0]};
        else if (win_hit[1])
            paddr = {cfg.dmw[1].pseg, addr[28:0]};
        else
            paddr = addr;   // miss, request is suppressed
    end

    assign adem = plv3 & addr[31] & ~(|win_hit);
    assign ale  = ((slot_req.size == exe_pkg::size_half) & addr[0]) |
                  ((slot_req.size == exe_pkg::size_word) & (|addr[1:0]));
    assign tlbr = ~cfg.da & ~(|win_hit);

    always_comb begin
        if (!slot_valid || !is_mem)
            exc_code = mmu_pkg::exc_none;
        else if (adem)
            exc_code = mmu_pkg::exc_adem;
        else if (ale)
            exc_code = mmu_pkg::exc_ale;
        else if (tlbr)
            exc_code = mmu_pkg::exc_tlbr;
        else
            exc_code = mmu_pkg::exc_none;
    end

    // only while the response side can take the item in the same cycle
    assign mem_valid = slot_valid & is_mem & (exc_code == mmu_pkg::exc_none) &
                       out_ready & ~flush;
    assign mem_done  = mem_valid & mem_ready;

    always_comb begin
        mem_req.wr   = is_store;
        mem_req.size = slot_req.size;
        mem_req.addr = paddr;
        case (slot_req.size)
            exe_pkg::size_byte: begin
                mem_req.wstrb = 4'b0001 << addr[1:0];
                mem_req.wdata = {4{slot_req.store_data[7:0]}};
            end
            exe_pkg::size_half: begin
                mem_req.wstrb = 4'b0011 << {addr[1], 1'b0};
                mem_req.wdata = {2{slot_req.store_data[15:0]}};
            end
            default: begin   // word
                mem_req.wstrb = 4'b1111;
                mem_req.wdata = slot_req.store_data;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exe_ctrl.sv */
// execute slot control
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  in_valid,
    input  exe_pkg::exe_req_t     in_req,
    input  logic                  out_ready,
    input  logic                  flush,
    input  logic [31:0]           alu_result,
    input  logic                  div_done,
    input  logic [31:0]           div_result,
    input  mmu_pkg::exc_code_e    exc_code,
    input  logic                  mem_done,
    output logic                  in_ready,
    output logic                  slot_valid,
    output exe_pkg::exe_req_t     slot_req,
    output logic                  div_start,
    output logic                  div_abort,
    output logic                  out_valid,
    output exe_pkg::exe_resp_t    out_resp
);

    logic in_is_div;
    logic slot_is_div;
    logic slot_is_mem;
    logic exc_valid;
    logic ready_go;
    logic out_fire;
    logic accept;

    assign in_is_div   = in_req.op inside {exe_pkg::op_div, exe_pkg::op_mod,
                                           exe_pkg::op_divu, exe_pkg::op_modu};
    assign slot_is_div = slot_req.op inside {exe_pkg::op_div, exe_pkg::op_mod,
                                             exe_pkg::op_divu, exe_pkg::op_modu};
    assign slot_is_mem = (slot_req.op == exe_pkg::op_load) || (slot_req.op == exe_pkg::op_store);
    assign exc_valid   = (exc_code != mmu_pkg::exc_none);

    // item finished its work in this cycle
    always_comb begin
        if (slot_is_div)
            ready_go = div_done;
        else if (slot_is_mem)
            ready_go = mem_done | exc_valid;   // request goes out with the response
        else
            ready_go = 1'b1;
    end

    assign out_valid = slot_valid & ready_go & ~flush;
    assign out_fire  = out_valid & out_ready;
    assign in_ready  = ~flush & (~slot_valid | out_fire);
    assign accept    = in_valid & in_ready;

    // divider is released on completion so its done flag cannot leak into the next divide
    assign div_abort = flush | (out_fire & slot_is_div);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            slot_valid <= 1'b0;
            div_start  <= 1'b0;
        end else begin
            div_start <= accept & in_is_div;   // one cycle, right after entry
            if (flush)
                slot_valid <= 1'b0;
            else if (in_ready)
                slot_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            slot_req <= in_req;
    end

    always_comb begin
        out_resp.result        = slot_is_div ? div_result : alu_result;
        out_resp.dest          = slot_req.dest;
        out_resp.gr_we         = slot_req.gr_we;
        out_resp.is_load       = (slot_req.op == exe_pkg::op_load);
        out_resp.load_unsigned = slot_req.load_unsigned;
        out_resp.size          = slot_req.size;
        out_resp.pc            = slot_req.pc;
        out_resp.exc_valid     = exc_valid;
        out_resp.exc_code      = exc_code;
    end

endmodule

`default_nettype wire

/* verilog/exe_stage.sv */
// execute stage top
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  logic                  clk,
    input  logic                  resetn,
    // from decode
    input  logic                  in_valid,
    output logic                  in_ready,
    input  exe_pkg::exe_req_t     in_req,
    // to memory stage
    output logic                  out_valid,
    input  logic                  out_ready,
    output exe_pkg::exe_resp_t    out_resp,
    // data memory
    output logic                  mem_valid,
    input  logic                  mem_ready,
    output exe_pkg::mem_req_t     mem_req,
    input  mmu_pkg::xlat_cfg_t    cfg,
    input  logic                  flush
);

    logic                  slot_valid;
    exe_pkg::exe_req_t     slot_req;
    logic [31:0]           alu_result;   // also the virtual address
    logic                  div_start;
    logic                  div_abort;
    logic                  div_done;
    logic [31:0]           div_result;
    mmu_pkg::exc_code_e    exc_code;
    logic                  mem_done;

    exe_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .out_ready  (out_ready),
        .flush      (flush),
        .alu_result (alu_result),
        .div_done   (div_done),
        .div_result (div_result),
        .exc_code   (exc_code),
        .mem_done   (mem_done),
        .in_ready   (in_ready),
        .slot_valid (slot_valid),
        .slot_req   (slot_req),
        .div_start  (div_start),
        .div_abort  (div_abort),
        .out_valid  (out_valid),
        .out_resp   (out_resp)
    );

    exe_alu u_alu (
        .op         (slot_req.op),
        .src1       (slot_req.src1),
        .src2       (slot_req.src2),
        .alu_result (alu_result)
    );

    exe_divider u_div (
        .clk        (clk),
        .resetn     (resetn),
        .div_start  (div_start),
        .div_abort  (div_abort),
        .op         (slot_req.op),
        .src1       (slot_req.src1),
        .src2       (slot_req.src2),
        .div_done   (div_done),
        .div_result (div_result)
    );

    exe_lsu u_lsu (
        .slot_valid (slot_valid),
        .slot_req   (slot_req),
        .addr       (alu_result),
        .cfg        (cfg),
        .out_ready  (out_ready),
        .flush      (flush),
        .mem_ready  (mem_ready),
        .exc_code   (exc_code),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_done   (mem_done)
    );

endmodule

`default_nettype wire

/* bench/exe_ref.svh */
// execute stage reference model
`ifndef EXE_REF_SVH
`define EXE_REF_SVH

// divide on magnitudes, then apply the sign rules
function automatic logic [31:0] divide_value(input exe_pkg::exe_op_e op,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic        sgn;
    logic [31:0] ua;
    logic [31:0] ub;
    logic [31:0] q;
    logic [31:0] r;
    sgn = (op == exe_pkg::op_div) || (op == exe_pkg::op_mod);
    ua  = (sgn && a[31]) ? 32'd0 - a : a;
    ub  = (sgn && b[31]) ? 32'd0 - b : b;
    if (ub == 32'd0) begin
        q = 32'hffff_ffff;   // zero divisor
        r = ua;
    end else begin
        q = ua / ub;
        r = ua % ub;
    end
    if (sgn && (a[31] ^ b[31]) && ub != 32'd0)
        q = 32'd0 - q;
    if (sgn && a[31])
        r = 32'd0 - r;   // remainder follows the dividend
    if (op == exe_pkg::op_mod || op == exe_pkg::op_modu)
        return r;
    return q;
endfunction

function automatic logic [31:0] result_value(input exe_pkg::exe_req_t req);
    logic [31:0] a;
    logic [31:0] b;
    a = req.src1;
    b = req.src2;
    case (req.op)
        exe_pkg::op_add:  return a + b;
        exe_pkg::op_sub:  return a - b;
        exe_pkg::op_slt:  return {31'd0, $signed(a) < $signed(b)};
        exe_pkg::op_sltu: return {31'd0, a < b};
        exe_pkg::op_and:  return a & b;
        exe_pkg::op_or:   return a | b;
        exe_pkg::op_xor:  return a ^ b;
        exe_pkg::op_nor:  return ~(a | b);
        exe_pkg::op_sll:  return a << b[4:0];
        exe_pkg::op_srl:  return a >> b[4:0];
        exe_pkg::op_sra:  return $signed(a) >>> b[4:0];
        exe_pkg::op_lui:  return b;
        exe_pkg::op_div, exe_pkg::op_mod,
        exe_pkg::op_divu, exe_pkg::op_modu: return divide_value(req.op, a, b);
        default:          return a + b;   // effective address
    endcase
endfunction

function automatic logic window_match(input mmu_pkg::xlat_cfg_t c, input mmu_pkg::dmw_t w,
                                      input logic [31:0] va);
    return (va[31:29] == w.vseg) &&
           ((c.plv == 2'd0 && w.plv0) || (c.plv == 2'd3 && w.plv3));
endfunction

function automatic logic [31:0] translate_addr(input mmu_pkg::xlat_cfg_t c,
                                               input logic [31:0] va);
    if (c.da)
        return va;
    if (window_match(c, c.dmw[0], va))
        return {c.dmw[0].pseg, va[28:0]};
    if (window_match(c, c.dmw[1], va))
        return {c.dmw[1].pseg, va[28:0]};
    return va;
endfunction

function automatic mmu_pkg::exc_code_e mem_exception(input mmu_pkg::xlat_cfg_t c,
                                                     input exe_pkg::exe_req_t req);
    logic [31:0] va;
    logic        hit;
    if (req.op != exe_pkg::op_load && req.op != exe_pkg::op_store)
        return mmu_pkg::exc_none;
    va  = req.src1 + req.src2;
    hit = window_match(c, c.dmw[0], va) || window_match(c, c.dmw[1], va);
    if (c.plv == 2'd3 && va[31] && !hit)
        return mmu_pkg::exc_adem;
    if ((req.size == exe_pkg::size_half && va[0]) ||
        (req.size == exe_pkg::size_word && va[1:0] != 2'b00))
        return mmu_pkg::exc_ale;
    if (!c.da && !hit)
        return mmu_pkg::exc_tlbr;
    return mmu_pkg::exc_none;
endfunction

function automatic exe_pkg::mem_req_t mem_request_for(input mmu_pkg::xlat_cfg_t c,
                                                      input exe_pkg::exe_req_t req);
    exe_pkg::mem_req_t m;
    logic [31:0]       va;
    va     = req.src1 + req.src2;
    m.wr   = (req.op == exe_pkg::op_store);
    m.size = req.size;
    m.addr = translate_addr(c, va);
    if (req.size == exe_pkg::size_byte) begin
        m.wstrb          = 4'b0000;
        m.wstrb[va[1:0]] = 1'b1;   // lane of the addressed byte
        m.wdata          = {4{req.store_data[7:0]}};
    end else if (req.size == exe_pkg::size_half) begin
        m.wstrb = va[1] ? 4'b1100 : 4'b0011;
        m.wdata = {2{req.store_data[15:0]}};
    end else begin
        m.wstrb = 4'b1111;
        m.wdata = req.store_data;
    end
    return m;
endfunction

function automatic exe_pkg::exe_resp_t response_for(input mmu_pkg::xlat_cfg_t c,
                                                    input exe_pkg::exe_req_t req);
    exe_pkg::exe_resp_t r;
    r.result        = result_value(req);
    r.dest          = req.dest;
    r.gr_we         = req.gr_we;
    r.is_load       = (req.op == exe_pkg::op_load);
    r.load_unsigned = req.load_unsigned;
    r.size          = req.size;
    r.pc            = req.pc;
    r.exc_code      = mem_exception(c, req);
    r.exc_valid     = (r.exc_code != mmu_pkg::exc_none);
    return r;
endfunction

`endif

/* bench/tb_exe.sv */
// execute stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exe;

    localparam int n_groups  = 24;
    localparam int per_group = 40;
    localparam int limit_ns  = n_groups * per_group * 40 * 8 + 2000;   // 40 cycles per request

    logic                 clk;
    logic                 resetn;
    logic                 in_valid;
    logic                 in_ready;
    exe_pkg::exe_req_t    in_req;
    logic                 out_valid;
    logic                 out_ready;
    exe_pkg::exe_resp_t   out_resp;
    logic                 mem_valid;
    logic                 mem_ready;
    exe_pkg::mem_req_t    mem_req;
    mmu_pkg::xlat_cfg_t   cfg;
    logic                 flush;

    logic [31:0]          rng;
    exe_pkg::exe_req_t    pend_q[$];   // accepted, not yet completed
    int                   acc_q[$];    // cycle of acceptance
    bit                   head_seen;
    int                   cycle     = 0;
    int                   errors    = 0;
    int                   checks    = 0;
    int                   completed = 0;
    int                   flushed   = 0;

    exe_stage dut (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_resp  (out_resp),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .cfg       (cfg),
        .flush     (flush)
    );

    `include "exe_ref.svh"

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic mmu_pkg::xlat_cfg_t pick_config();
        mmu_pkg::xlat_cfg_t c;
        logic [31:0]        bits;
        bits   = next_rand();
        c.da   = (bits[1:0] == 2'b00);
        c.pg   = ~c.da;
        c.plv  = (bits[4:2] < 3'd3) ? 2'd0 : ((bits[4:2] < 3'd7) ? 2'd3 : 2'd1);
        c.dmw[0] = bits[13:5];
        c.dmw[1] = bits[22:14];
        c.dmw[0].plv0 = c.dmw[0].plv0 | bits[23];   // lean toward enabled windows
        c.dmw[1].plv3 = c.dmw[1].plv3 | bits[24];
        return c;
    endfunction

    function automatic exe_pkg::exe_req_t make_request();
        exe_pkg::exe_req_t r;
        logic [31:0]       pick;
        logic [31:0]       bits;
        logic [2:0]        seg;
        pick            = next_rand() % 22;
        bits            = next_rand();
        r.src1          = next_rand();
        r.src2          = next_rand();
        r.store_data    = next_rand();
        r.pc            = next_rand() & 32'hffff_fffc;
        r.size          = (bits[1:0] == 2'd3) ? exe_pkg::size_word
                                              : exe_pkg::mem_size_e'(bits[1:0]);
        r.load_unsigned = bits[2];
        r.dest          = bits[7:3];
        r.gr_we         = bits[8];
        if (pick < 16) begin
            r.op = exe_pkg::exe_op_e'(pick[4:0]);
            if (pick >= 12 && bits[10:9] == 2'd0)
                r.src2 = 32'd0;   // zero divisor
            else if (pick >= 12 && bits[10:9] == 2'd1)
                r.src2 = {28'd0, bits[14:11]};
        end else begin
            r.op = bits[9] ? exe_pkg::op_store : exe_pkg::op_load;
            case (bits[11:10])
                2'd0:    seg = cfg.dmw[0].vseg;
                2'd1:    seg = cfg.dmw[1].vseg;
                default: seg = bits[14:12];
            endcase
            r.src1[31:29] = seg;
            r.src2 = {{20{bits[27]}}, bits[27:16]};   // 12-bit signed offset
            if (bits[30:28] != 3'd0) begin   // mostly aligned
                r.src2[1:0] = 2'b00;
                if (r.size == exe_pkg::size_word)
                    r.src1[1:0] = 2'b00;
                else if (r.size == exe_pkg::size_half)
                    r.src1[0] = 1'b0;
            end
        end
        return r;
    endfunction

    task automatic drive_stalls();
        out_ready <= (next_rand() % 4) != 0;
        mem_ready <= (next_rand() % 3) != 0;
        flush     <= (next_rand() % 50) == 0;
    endtask

    task automatic drop_head();
        void'(pend_q.pop_front());
        void'(acc_q.pop_front());
        head_seen = 1'b0;
    endtask

    // sampled at the edge, before the DUT registers update
    always @(posedge clk) begin : monitor
        exe_pkg::exe_req_t head;
        logic              is_mem;
        logic              no_exc;
        int                lat;
        if (resetn) begin
            cycle = cycle + 1;
            // slot frees up when empty or when the held item leaves now
            check(128'(in_ready),
                  128'(!flush && (pend_q.size() == 0 || (out_valid && out_ready))),
                  "in_ready");
            check(128'((out_valid | mem_valid) & flush), 128'(0), "valid during flush");
            check(128'(mem_valid & ~out_ready), 128'(0), "mem_valid while out_ready low");
            check(128'(mem_valid & mem_ready & ~(out_valid & out_ready)), 128'(0),
                  "memory transfer without response");
            if ((out_valid || mem_valid) && pend_q.size() == 0) begin
                errors++;
                $display("error at %0t: output raised with no request outstanding", $time);
            end else if (pend_q.size() != 0) begin
                head   = pend_q[0];
                is_mem = (head.op == exe_pkg::op_load) || (head.op == exe_pkg::op_store);
                no_exc = (mem_exception(cfg, head) == mmu_pkg::exc_none);
                if (mem_valid) begin
                    check(128'(no_exc), 128'(1), "memory request for an excepting access");
                    check(128'(mem_req), 128'(mem_request_for(cfg, head)), "memory request");
                end
                // memory ops without exception wait on the memory handshake
                if (out_valid && !head_seen && !(is_mem && no_exc)) begin
                    lat = (head.op inside {exe_pkg::op_div, exe_pkg::op_mod,
                                           exe_pkg::op_divu, exe_pkg::op_modu}) ? 34 : 1;
                    check(128'(cycle - acc_q[0]), 128'(lat), "out_valid latency");
                end
                if (out_valid)
                    head_seen = 1'b1;
                if (flush) begin
                    drop_head();
                    flushed++;
                end else if (out_valid && out_ready) begin
                    check(128'(out_resp), 128'(response_for(cfg, head)), "response");
                    if (is_mem && no_exc)
                        check(128'(mem_valid & mem_ready), 128'(1),
                              "memory transfer with response");
                    drop_head();
                    completed++;
                end
            end
            if (in_valid && in_ready) begin
                pend_q.push_back(in_req);
                acc_q.push_back(cycle);
            end
        end
    end

    initial begin : stimulus
        int sent;
        rng       = 32'h7f4fd608;
        clk       = 1'b0;
        resetn    = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        mem_ready = 1'b0;
        flush     = 1'b0;
        cfg       = '0;
        head_seen = 1'b0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        for (int g = 0; g < n_groups; g++) begin
            @(posedge clk);
            cfg <= pick_config();   // slot is empty here
            drive_stalls();
            sent = 0;
            while (sent < per_group) begin
                @(posedge clk);
                if (in_valid && in_ready)
                    sent++;
                drive_stalls();
                if (!in_valid || in_ready) begin
                    if (sent < per_group && (next_rand() % 4) != 0) begin
                        in_valid <= 1'b1;
                        in_req   <= make_request();
                    end else begin
                        in_valid <= 1'b0;
                    end
                end
            end
            // drain before the next configuration
            do begin
                @(posedge clk);
                drive_stalls();
                #1;
            end while (pend_q.size() != 0);
        end
        $display("completed %0d, flushed %0d, checks %0d, errors %0d",
                 completed, flushed, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin : watchdog
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+bench
verilog/mmu_pkg.sv
verilog/exe_pkg.sv
verilog/exe_alu.sv
verilog/exe_divider.sv
verilog/exe_lsu.sv
verilog/exe_ctrl.sv
verilog/exe_stage.sv
bench/tb_exe.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_exe \
    -Mdir obj_dir -o sim_exe > build.log 2>&1 &&
./obj_dir/sim_exe > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } ||
echo "simulation finished without failure"
